/* common/cfu_defs.svh */
`ifndef CFU_DEFS_SVH
`define CFU_DEFS_SVH

// Buffer geometry
`define CFU_A_ADDR_BITS 8
`define CFU_B_ADDR_BITS 8
`define CFU_A_DATA_BITS 8
`define CFU_B_DATA_BITS 32

// Dot-product row
`define CFU_LANES 4
`define CFU_ACC_BITS 32
`define CFU_LEN_BITS 10

// funct7 command codes
`define CFU_OP_WRITE_A 1
`define CFU_OP_WRITE_B 2
`define CFU_OP_COMPUTE 3
`define CFU_OP_READ 4

`endif

/* common/cfu_pkg.sv */
`default_nettype none
`include "cfu_defs.svh"

package cfu_pkg;

  // Command channel payload
  typedef struct packed {
    logic [6:0]  funct7;
    logic [2:0]  funct3;
    logic [31:0] operand0;
    logic [31:0] operand1;
  } cfu_cmd_t;

  // operand0 is a buffer address for writes, the length K for compute
  typedef union packed {
    struct packed {
      logic [31-`CFU_A_ADDR_BITS:0] pad;
      logic [`CFU_A_ADDR_BITS-1:0]  addr;
    } addr_view;
    struct packed {
      logic [31-`CFU_LEN_BITS:0] pad;
      logic [`CFU_LEN_BITS-1:0]  k_len;
    } len_view;
  } cfu_operand0_u;

  typedef struct packed {
    logic [31:0] data;
  } cfu_rsp_t;

  typedef struct packed {
    logic                        we;
    logic [`CFU_A_ADDR_BITS-1:0] addr;
    logic [`CFU_A_DATA_BITS-1:0] data;
  } buf_port_a_t;

  typedef struct packed {
    logic                        we;
    logic [`CFU_B_ADDR_BITS-1:0] addr;
    logic [`CFU_B_DATA_BITS-1:0] data;
  } buf_port_b_t;

  // Lane 0 sits in the most significant slot
  typedef logic [0:`CFU_LANES-1][7:0] lane_vec_t;
  typedef logic [0:`CFU_LANES-1][`CFU_ACC_BITS-1:0] result_row_t;

endpackage

`default_nettype wire

/* tpu/mac_pe.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cfu_defs.svh"

module mac_pe (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            clear,
  input  logic signed [7:0]               north,
  input  logic signed [7:0]               west,
  output logic signed [7:0]               east,
  output logic signed [`CFU_ACC_BITS-1:0] result
);

  logic signed [15:0]               prod;
  logic signed [`CFU_ACC_BITS-1:0]  acc_q;
  logic signed [7:0]                east_q;

  assign prod = north * west;

  // Accumulator wraps at 32 bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q  <= '0;
      east_q <= '0;
    end else begin
      if (clear) begin
        acc_q <= '0;
      end else begin
        acc_q <= acc_q + prod;
      end
      east_q <= west;
    end
  end

  assign east   = east_q;
  assign result = acc_q;

endmodule

`default_nettype wire

/* tpu/mac_row.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cfu_defs.svh"

module mac_row
  import cfu_pkg::*;
(
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               clear,
  input  logic signed [`CFU_A_DATA_BITS-1:0] a_in,
  input  lane_vec_t                          b_in,
  output result_row_t                        acc
);

  // A enters PE 0 and hops one PE per cycle
  logic signed [7:0]               a_west [`CFU_LANES];
  logic signed [7:0]               a_east [`CFU_LANES];
  logic [`CFU_ACC_BITS-1:0]        pe_res [`CFU_LANES];

  assign a_west[0] = a_in;

  for (genvar j = 0; j < `CFU_LANES; j++) begin : g_pe
    mac_pe u_pe (
      .clk    (clk),
      .rst_n  (rst_n),
      .clear  (clear),
      .north  (b_in[j]),
      .west   (a_west[j]),
      .east   (a_east[j]),
      .result (pe_res[j])
    );

    if (j > 0) begin : g_link
      assign a_west[j] = a_east[j-1];
    end
  end

  // Lane 0 lands in the top word
  always_comb begin
    for (int i = 0; i < `CFU_LANES; i++) begin
      acc[i] = pe_res[i];
    end
  end

endmodule

`default_nettype wire

/* tpu/tpu_seq.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cfu_defs.svh"

module tpu_seq
  import cfu_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic [`CFU_LEN_BITS-1:0]    k_len,
  output logic                        busy,
  output logic [`CFU_A_ADDR_BITS-1:0] a_addr,
  output logic [`CFU_B_ADDR_BITS-1:0] b_addr,
  input  logic [`CFU_A_DATA_BITS-1:0] a_rdata,
  input  lane_vec_t                   b_rdata,
  output result_row_t                 result
);

  // Buffer read plus feed register
  localparam int FEED_DLY = 2;
  localparam int CNT_BITS = `CFU_LEN_BITS + 1;

  logic                              busy_q;
  logic [`CFU_LEN_BITS-1:0]          k_q;
  logic [`CFU_LEN_BITS-1:0]          idx_q;
  logic [CNT_BITS-1:0]               cnt_q;
  logic                              issue;
  logic                              rd_vld_q;
  logic                              capture;
  logic signed [`CFU_A_DATA_BITS-1:0] a_feed_q;
  lane_vec_t                         b_feed_q;
  logic [7:0]                        sk1_q;
  logic [1:0][7:0]                   sk2_q;
  logic [2:0][7:0]                   sk3_q;
  lane_vec_t                         b_in;
  logic                              clear;
  result_row_t                       acc;
  result_row_t                       result_q;

  assign issue   = busy_q && (idx_q != k_q);
  // Last pair leaves PE 3 three cycles after PE 0
  assign capture = busy_q && (cnt_q == {1'b0, k_q} + CNT_BITS'(FEED_DLY + 3));
  assign clear   = start;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q   <= 1'b0;
      k_q      <= '0;
      idx_q    <= '0;
      cnt_q    <= '0;
      rd_vld_q <= 1'b0;
      result_q <= '0;
    end else begin
      rd_vld_q <= issue;
      if (start) begin
        busy_q <= 1'b1;
        k_q    <= k_len;
        idx_q  <= '0;
        cnt_q  <= '0;
      end else if (busy_q) begin
        cnt_q <= cnt_q + 1'b1;
        if (issue) idx_q <= idx_q + 1'b1;
        if (capture) busy_q <= 1'b0;
      end
      if (capture) result_q <= acc;
    end
  end

  // Zero outside the read window so idle cycles add nothing
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_feed_q <= '0;
      b_feed_q <= '0;
      sk1_q    <= '0;
      sk2_q    <= '0;
      sk3_q    <= '0;
    end else begin
      a_feed_q <= rd_vld_q ? a_rdata : '0;
      b_feed_q <= rd_vld_q ? b_rdata : '0;
      sk1_q    <= b_feed_q[1];
      sk2_q    <= {sk2_q[0], b_feed_q[2]};
      sk3_q    <= {sk3_q[1:0], b_feed_q[3]};
    end
  end

  // Lane j lags by j cycles to meet A in PE j
  assign b_in = {b_feed_q[0], sk1_q, sk2_q[1], sk3_q[2]};

  mac_row u_mac_row (
    .clk   (clk),
    .rst_n (rst_n),
    .clear (clear),
    .a_in  (a_feed_q),
    .b_in  (b_in),
    .acc   (acc)
  );

  assign busy   = busy_q;
  assign a_addr = idx_q[`CFU_A_ADDR_BITS-1:0];
  assign b_addr = idx_q[`CFU_B_ADDR_BITS-1:0];
  assign result = result_q;

  start_idle_a: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> !busy_q);

endmodule

`default_nettype wire

/* design/scratch_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module scratch_buffer #(
  parameter int ADDR_BITS = 8,
  parameter int DATA_BITS = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wr_en,
  input  logic [ADDR_BITS-1:0] addr,
  input  logic [DATA_BITS-1:0] wdata,
  output logic [DATA_BITS-1:0] rdata
);

  localparam int DEPTH = 2 ** ADDR_BITS;

  logic [DATA_BITS-1:0] mem [DEPTH];

  // Single port, a write cycle leaves rdata unchanged
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end else if (wr_en) begin
      mem[addr] <= wdata;
    end else begin
      rdata <= mem[addr];
    end
  end

endmodule

`default_nettype wire

/* design/cfu_cmd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cfu_defs.svh"

module cfu_cmd_ctrl
  import cfu_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cmd_valid,
  output logic                        cmd_ready,
  input  cfu_cmd_t                    cmd,
  output logic                        rsp_valid,
  input  logic                        rsp_ready,
  output cfu_rsp_t                    rsp,
  output buf_port_a_t                 port_a,
  output buf_port_b_t                 port_b,
  input  logic [`CFU_A_ADDR_BITS-1:0] seq_a_addr,
  input  logic [`CFU_B_ADDR_BITS-1:0] seq_b_addr,
  output logic                        start,
  output logic [`CFU_LEN_BITS-1:0]    k_len,
  input  logic                        busy,
  input  result_row_t                 result
);

  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_WR_A  = 3'd1;
  localparam logic [2:0] S_WR_B  = 3'd2;
  localparam logic [2:0] S_START = 3'd3;
  localparam logic [2:0] S_WAIT  = 3'd4;
  localparam logic [2:0] S_READ  = 3'd5;
  localparam logic [2:0] S_RESP  = 3'd6;

  logic [2:0]    state_q;
  logic [2:0]    state_d;
  cfu_cmd_t      cmd_q;
  cfu_operand0_u op0;
  cfu_rsp_t      rsp_q;

  assign op0 = cmd_q.operand0;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (cmd_valid) begin
          case (cmd.funct7)
            `CFU_OP_WRITE_A: state_d = S_WR_A;
            `CFU_OP_WRITE_B: state_d = S_WR_B;
            `CFU_OP_COMPUTE: state_d = S_START;
            `CFU_OP_READ:    state_d = S_READ;
            // Unknown opcode answers zero straight away
            default:         state_d = S_RESP;
          endcase
        end
      end
      S_WR_A, S_WR_B, S_READ: state_d = S_RESP;
      S_START: state_d = S_WAIT;
      // busy is already high on the first wait cycle
      S_WAIT: if (!busy) state_d = S_RESP;
      S_RESP: if (rsp_ready) state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
      cmd_q   <= '0;
      rsp_q   <= '0;
    end else begin
      state_q <= state_d;
      if (cmd_valid && cmd_ready) begin
        cmd_q <= cmd;
        rsp_q <= '0;
      end
      // Lane select from operand1, address field ignored
      if (state_q == S_READ) begin
        rsp_q.data <= result[cmd_q.operand1[1:0]];
      end
    end
  end

  assign cmd_ready = (state_q == S_IDLE);
  assign rsp_valid = (state_q == S_RESP);
  assign rsp       = rsp_q;
  assign start     = (state_q == S_START);
  assign k_len     = op0.len_view.k_len;

  // Sequencer owns the buffer addresses while computing
  always_comb begin
    port_a.we   = (state_q == S_WR_A);
    port_a.addr = busy ? seq_a_addr : op0.addr_view.addr;
    port_a.data = cmd_q.operand1[31 -: `CFU_A_DATA_BITS];
    port_b.we   = (state_q == S_WR_B);
    port_b.addr = busy ? seq_b_addr : op0.addr_view.addr;
    port_b.data = cmd_q.operand1;
  end

  rsp_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

endmodule

`default_nettype wire

/* design/cfu_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cfu_defs.svh"

module cfu_top
  import cfu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     cmd_valid,
  output logic     cmd_ready,
  input  cfu_cmd_t cmd,
  output logic     rsp_valid,
  input  logic     rsp_ready,
  output cfu_rsp_t rsp
);

  buf_port_a_t                 port_a;
  buf_port_b_t                 port_b;
  logic [`CFU_A_ADDR_BITS-1:0] seq_a_addr;
  logic [`CFU_B_ADDR_BITS-1:0] seq_b_addr;
  logic [`CFU_A_DATA_BITS-1:0] a_rdata;
  lane_vec_t                   b_rdata;
  logic                        start;
  logic [`CFU_LEN_BITS-1:0]    k_len;
  logic                        busy;
  result_row_t                 result;

  cfu_cmd_ctrl u_cmd_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd        (cmd),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp        (rsp),
    .port_a     (port_a),
    .port_b     (port_b),
    .seq_a_addr (seq_a_addr),
    .seq_b_addr (seq_b_addr),
    .start      (start),
    .k_len      (k_len),
    .busy       (busy),
    .result     (result)
  );

  scratch_buffer #(
    .ADDR_BITS (`CFU_A_ADDR_BITS),
    .DATA_BITS (`CFU_A_DATA_BITS)
  ) buf_a (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (port_a.we),
    .addr  (port_a.addr),
    .wdata (port_a.data),
    .rdata (a_rdata)
  );

  scratch_buffer #(
    .ADDR_BITS (`CFU_B_ADDR_BITS),
    .DATA_BITS (`CFU_B_DATA_BITS)
  ) buf_b (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (port_b.we),
    .addr  (port_b.addr),
    .wdata (port_b.data),
    .rdata (b_rdata)
  );

  tpu_seq u_tpu_seq (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .k_len   (k_len),
    .busy    (busy),
    .a_addr  (seq_a_addr),
    .b_addr  (seq_b_addr),
    .a_rdata (a_rdata),
    .b_rdata (b_rdata),
    .result  (result)
  );

endmodule

`default_nettype wire

/* verification/tb_cfu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cfu_defs.svh"

module tb_cfu
  import cfu_pkg::*;
();

  localparam int          RESET_CYCLES = 8;
  localparam int          MAX_K        = 64;
  localparam logic [31:0] SEED         = 32'h9a3d3e56;

  // One row of the stimulus table
  typedef struct packed {
    logic [6:0]  funct7;
    logic [31:0] operand0;
    logic [31:0] operand1;
    logic [31:0] expected;
    logic [3:0]  stall;
  } op_entry_t;

  logic     clk;
  logic     rst_n;
  logic     cmd_valid;
  logic     cmd_ready;
  cfu_cmd_t cmd;
  logic     rsp_valid;
  logic     rsp_ready;
  cfu_rsp_t rsp;

  op_entry_t   ops[$];
  logic        table_done = 1'b0;
  logic [31:0] rng_state;

  // Reference copies of both buffers and the last result row
  logic [7:0]  a_model [256];
  logic [31:0] b_model [256];
  logic [31:0] row_model [`CFU_LANES];

  always #4 clk = ~clk;

  cfu_top i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
  );

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Signed dot product of A with byte lane j of B, wraps at 32 bits
  function automatic logic [31:0] dot_lane(input int k_len, input int lane);
    int                sum;
    logic signed [7:0] a_val;
    logic signed [7:0] b_val;
    sum = 0;
    for (int k = 0; k < k_len; k++) begin
      a_val = a_model[k];
      b_val = b_model[k][31 - 8*lane -: 8];
      sum   = sum + a_val * b_val;
    end
    return sum;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: actual 0x%08h expected 0x%08h", name, actual, expected);
      $display("SOME TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic add_op(input logic [6:0] funct7, input logic [31:0] op0,
                        input logic [31:0] op1, input logic [31:0] expected,
                        input logic [3:0] stall);
    op_entry_t e;
    e.funct7   = funct7;
    e.operand0 = op0;
    e.operand1 = op1;
    e.expected = expected;
    e.stall    = stall;
    ops.push_back(e);
  endtask

  // Random upper address bits must be ignored
  task automatic write_entry(input logic is_b, input int addr, input logic [31:0] word);
    logic [31:0] r;
    logic [31:0] op0;
    r   = next_rand();
    op0 = {r[31:8], addr[7:0]};
    if (is_b) begin
      b_model[addr] = word;
      add_op(7'(`CFU_OP_WRITE_B), op0, word, 32'd0, {2'b00, r[1:0]});
    end else begin
      a_model[addr] = word[31:24];
      add_op(7'(`CFU_OP_WRITE_A), op0, word, 32'd0, {2'b00, r[1:0]});
    end
  endtask

  task automatic compute_entry(input int k);
    logic [31:0] r;
    r = next_rand();
    for (int j = 0; j < `CFU_LANES; j++) begin
      row_model[j] = dot_lane(k, j);
    end
    add_op(7'(`CFU_OP_COMPUTE), {r[31:10], k[9:0]}, ~r, 32'd0, 4'd0);
  endtask

  // Reads always see some back-pressure
  task automatic read_entry(input int lane);
    logic [31:0] r;
    logic [3:0]  stall;
    r     = next_rand();
    stall = 4'(1 + r[31:29]);
    add_op(7'(`CFU_OP_READ), ~r, {r[31:2], lane[1:0]}, row_model[lane], stall);
  endtask

  task automatic build_table();
    int k1;
    int k2;
    for (int i = 0; i < 256; i++) begin
      a_model[i] = '0;
      b_model[i] = '0;
    end
    for (int j = 0; j < `CFU_LANES; j++) begin
      row_model[j] = '0;
    end
    // Row is zero before any compute
    for (int j = 0; j < `CFU_LANES; j++) read_entry(j);
    add_op(7'h55, 32'h1234_5678, 32'h9abc_def0, 32'd0, 4'd2);
    // K of 1, mixed signs: -7 times 127, -128, 5, -2
    write_entry(1'b0, 0, 32'hf9a5_5a00);
    write_entry(1'b1, 0, 32'h7f80_05fe);
    compute_entry(1);
    for (int j = 0; j < `CFU_LANES; j++) read_entry(j);
    // Random contents over the whole K range
    for (int i = 0; i < MAX_K; i++) begin
      write_entry(1'b0, i, next_rand());
      write_entry(1'b1, i, next_rand());
    end
    k1 = 1 + int'(next_rand() % MAX_K);
    compute_entry(k1);
    for (int j = 0; j < `CFU_LANES; j++) read_entry(j);
    // New length replaces the row
    k2 = k1;
    while (k2 == k1) k2 = 1 + int'(next_rand() % MAX_K);
    compute_entry(k2);
    for (int j = 0; j < `CFU_LANES; j++) read_entry(j);
  endtask

  // Called and returns on a falling edge
  task automatic apply_op(input op_entry_t op);
    cfu_rsp_t held;
    cmd.funct7   = op.funct7;
    cmd.funct3   = 3'd0;
    cmd.operand0 = op.operand0;
    cmd.operand1 = op.operand1;
    cmd_valid    = 1'b1;
    rsp_ready    = (op.stall == 4'd0);
    while (!cmd_ready) @(negedge clk);
    @(negedge clk);
    cmd_valid = 1'b0;
    cmd       = {next_rand(), next_rand(), 10'h3ff};
    while (!rsp_valid) @(negedge clk);
    check_value("rsp", rsp.data, op.expected);
    held = rsp;
    if (op.stall != 4'd0) begin
      // Competing write that must stay blocked
      cmd       = {7'(`CFU_OP_WRITE_B), 3'd0, 32'd0, next_rand()};
      cmd_valid = 1'b1;
      for (int s = 0; s < int'(op.stall); s++) begin
        @(negedge clk);
        check_value("rsp_valid", 32'(rsp_valid), 32'd1);
        check_value("rsp", rsp.data, held.data);
        check_value("cmd_ready", 32'(cmd_ready), 32'd0);
      end
      cmd_valid = 1'b0;
      rsp_ready = 1'b1;
    end
    @(negedge clk);
    check_value("rsp_valid", 32'(rsp_valid), 32'd0);
    check_value("cmd_ready", 32'(cmd_ready), 32'd1);
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd       = '0;
    rsp_ready = 1'b1;
    rng_state = SEED;
    build_table();
    table_done = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("cmd_ready", 32'(cmd_ready), 32'd1);
    check_value("rsp_valid", 32'(rsp_valid), 32'd0);
    for (int i = 0; i < ops.size(); i++) begin
      apply_op(ops[i]);
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

  // Each entry gets the longest compute plus margin
  initial begin
    int limit;
    wait (table_done);
    limit = (ops.size() + 1) * (MAX_K + 20) + RESET_CYCLES;
    repeat (limit) @(posedge clk);
    $display("Timeout: command table not finished after %0d cycles", limit);
    $display("SOME TESTS FAILED");
    $fatal(1);
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+common
common/cfu_pkg.sv
tpu/mac_pe.sv
tpu/mac_row.sv
tpu/tpu_seq.sv
design/scratch_buffer.sv
design/cfu_cmd_ctrl.sv
design/cfu_top.sv
verification/tb_cfu.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the CFU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_cfu -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_cfu)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
